// ==== buffer_reader.sv ====
`timescale 1ns/100ps
`default_nettype none

module buffer_reader
   import wu_cfg_pkg::*;
(
   input  wire                   clk,
   input  wire                   rst,
   input  wire                   run_i,
   input  wire wu_cfg_t          cfg_i,
   input  wire                   half_i,
   output logic                  re_o,
   output logic [BUF_ADDR_W-1:0] raddr_o,
   input  wire  [DATA_W-1:0]     rdata_i,
   word_stream_if.src            out
);

   logic                  busy_q;
   logic [BUF_ADDR_W-1:0] idx_q;
   // word sitting on the RAM output
   logic                  pend_v_q;
   logic                  pend_last_q;
   // word parked while the bus stalls
   logic                  hold_v_q;
   logic                  hold_last_q;
   logic [DATA_W-1:0]     hold_data_q;
   logic                  pop;
   logic                  issue;
   logic                  idx_last;

   assign pop      = out.valid && out.ready;
   // read only if the holding register is free after this edge
   assign issue    = busy_q && (!hold_v_q || pop);
   assign idx_last = (idx_q == BUF_ADDR_W'(cfg_i.xfer_amount - 1'b1));

   assign re_o    = issue;
   assign raddr_o = {half_i, idx_q[BUF_ADDR_W-2:0]};

   // hold is always older than the RAM word
   assign out.valid = hold_v_q || pend_v_q;
   assign out.data  = hold_v_q ? hold_data_q : rdata_i;
   assign out.last  = hold_v_q ? hold_last_q : pend_last_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         busy_q <= 1'b0;
         idx_q  <= '0;
      end else if (run_i) begin
         busy_q <= cfg_i.xfer_enable && (cfg_i.xfer_amount != '0);
         idx_q  <= '0;
      end else if (issue) begin
         idx_q <= idx_q + 1'b1;
         if (idx_last) begin
            busy_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         pend_v_q    <= 1'b0;
         pend_last_q <= 1'b0;
         hold_v_q    <= 1'b0;
      end else begin
         pend_v_q <= issue || (pend_v_q && hold_v_q && !pop);
         if (issue) begin
            pend_last_q <= idx_last;
         end
         if (hold_v_q) begin
            hold_v_q <= !pop || pend_v_q;
         end else begin
            hold_v_q <= pend_v_q && !pop;
         end
      end
   end

   // RAM word moves into hold when hold drains or when the bus stalls
   always_ff @(posedge clk) begin
      if (pend_v_q && (hold_v_q == pop)) begin
         hold_data_q <= rdata_i;
         hold_last_q <= pend_last_q;
      end
   end

endmodule

`default_nettype wire

// ==== burst_writer.sv ====
`timescale 1ns/100ps
`default_nettype none

module burst_writer
   import wu_bus_pkg::*;
   import wu_cfg_pkg::*;
(
   input  wire                   clk,
   input  wire                   rst,
   input  wire                   run_i,
   input  wire wu_cfg_t          cfg_i,
   word_stream_if.dst            in,
   output logic                  databus_valid_o,
   input  wire                   databus_ready_i,
   output logic [AXI_ADDR_W-1:0] databus_addr_o,
   output logic [AXI_DATA_W-1:0] databus_wdata_o,
   output logic [STRB_W-1:0]     databus_wstrb_o,
   output logic [LEN_W-1:0]      databus_len_o,
   output logic                  databus_last_o,
   output logic                  done_o
);

   // words not yet covered by a finished burst
   logic [BUF_ADDR_W-1:0] rem_q;
   logic [LEN_W-1:0]      beat_q;
   logic [AXI_ADDR_W-1:0] addr_q;
   logic [LEN_W-1:0]      burst_len;
   logic                  beat_ok;
   logic                  beat_last;

   // rem only moves at burst end, so len holds for the whole burst
   assign burst_len = (BUF_ADDR_W'(cfg_i.xfer_len) > rem_q) ? LEN_W'(rem_q) : cfg_i.xfer_len;
   assign beat_last = (beat_q == burst_len - 1'b1);
   assign beat_ok   = in.valid && databus_ready_i;

   assign in.ready        = databus_ready_i;
   assign databus_valid_o = in.valid;
   assign databus_wdata_o = in.data;
   assign databus_wstrb_o = WSTRB_ALL;
   assign databus_addr_o  = addr_q;
   assign databus_len_o   = burst_len;
   assign databus_last_o  = in.valid && beat_last;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rem_q  <= '0;
         beat_q <= '0;
         addr_q <= '0;
         done_o <= 1'b1;
      end else if (run_i) begin
         rem_q  <= cfg_i.xfer_amount;
         beat_q <= '0;
         addr_q <= cfg_i.xfer_ext_addr;
         // nothing to send counts as done
         done_o <= !(cfg_i.xfer_enable && (cfg_i.xfer_amount != '0));
      end else if (beat_ok) begin
         if (beat_last) begin
            beat_q <= '0;
            rem_q  <= rem_q - BUF_ADDR_W'(burst_len);
            addr_q <= addr_q + cfg_i.xfer_addr_stride;
         end else begin
            beat_q <= beat_q + 1'b1;
         end
         if (in.last) begin
            done_o <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== dual_port_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module dual_port_buffer
   import wu_cfg_pkg::*;
(
   input  wire                   clk,
   input  wire                   we_i,
   input  wire  [BUF_ADDR_W-1:0] waddr_i,
   input  wire  [DATA_W-1:0]     wdata_i,
   input  wire                   re_i,
   input  wire  [BUF_ADDR_W-1:0] raddr_i,
   output logic [DATA_W-1:0]     rdata_o
);

   logic [DATA_W-1:0] mem [BUF_DEPTH];

   always_ff @(posedge clk) begin
      if (we_i) begin
         mem[waddr_i] <= wdata_i;
      end
   end

   // read-before-write on a shared address
   always_ff @(posedge clk) begin
      if (re_i) begin
         rdata_o <= mem[raddr_i];
      end
   end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the write unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/100ps --top-module tb_write_unit \
   -f sim.f -o tb_write_unit_sim || { echo "build failed"; exit 1; }
result=$(./obj_dir/tb_write_unit_sim 2>&1)
echo "$result"
echo "$result" | grep -qF '*** PASSED ***' \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

// ==== sim.f ====
wu_bus_pkg.sv
wu_cfg_pkg.sv
word_stream_if.sv
store_addr_gen.sv
dual_port_buffer.sv
buffer_reader.sv
burst_writer.sv
write_unit.sv
tb_write_unit.sv

// ==== store_addr_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module store_addr_gen
   import wu_cfg_pkg::*;
(
   input  wire                    clk,
   input  wire                    rst,
   input  wire                    run_i,
   input  wire wu_cfg_t           cfg_i,
   input  wire                    half_i,
   output logic                   we_o,
   output logic [BUF_ADDR_W-1:0]  addr_o,
   output logic                   done_o
);

   logic                  busy_q;
   logic [DELAY_W-1:0]    dly_q;
   logic [LOOP_W-1:0]     j_q;
   logic [LOOP_W-1:0]     i_q;
   logic [BUF_ADDR_W-1:0] addr_q;
   logic [BUF_ADDR_W-1:0] row_q;
   logic                  step;
   logic                  inner_end;
   logic                  outer_end;

   // one write per cycle once the delay has run out
   assign step      = busy_q && (dly_q == '0);
   assign inner_end = (j_q == cfg_i.store_period - 1'b1);
   assign outer_end = (i_q == cfg_i.store_iter - 1'b1);

   assign we_o   = step;
   // wrap inside one half and take the half bit from ping-pong state
   assign addr_o = {half_i, addr_q[BUF_ADDR_W-2:0]};

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         busy_q <= 1'b0;
         done_o <= 1'b1;
         dly_q  <= '0;
         j_q    <= '0;
         i_q    <= '0;
         addr_q <= '0;
         row_q  <= '0;
      end else if (run_i) begin
         dly_q  <= cfg_i.store_delay;
         j_q    <= '0;
         i_q    <= '0;
         addr_q <= cfg_i.store_start;
         row_q  <= cfg_i.store_start;
         // empty pattern finishes right away
         if (cfg_i.store_period == '0 || cfg_i.store_iter == '0) begin
            busy_q <= 1'b0;
            done_o <= 1'b1;
         end else begin
            busy_q <= 1'b1;
            done_o <= 1'b0;
         end
      end else if (busy_q) begin
         if (dly_q != '0) begin
            dly_q <= dly_q - 1'b1;
         end else if (inner_end) begin
            j_q <= '0;
            if (outer_end) begin
               busy_q <= 1'b0;
               done_o <= 1'b1;
            end else begin
               // next row starts one stride past the previous row base
               i_q    <= i_q + 1'b1;
               row_q  <= row_q + cfg_i.store_stride;
               addr_q <= row_q + cfg_i.store_stride;
            end
         end else begin
            j_q    <= j_q + 1'b1;
            addr_q <= addr_q + cfg_i.store_incr;
         end
      end
   end

endmodule

`default_nettype wire

// ==== tb_write_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_write_unit
   import wu_bus_pkg::*;
   import wu_cfg_pkg::*;
();

   localparam int NUM_ROWS    = 11;
   localparam int RUN_TIMEOUT = 3000;

   logic                  clk = 1'b0;
   logic                  rst;
   logic                  run_i;
   logic                  done_o;
   logic [DATA_W-1:0]     in_i = '0;
   wu_cfg_t               cfg;
   logic                  databus_valid_o;
   logic                  databus_ready_i = 1'b0;
   logic [AXI_ADDR_W-1:0] databus_addr_o;
   logic [AXI_DATA_W-1:0] databus_wdata_o;
   logic [STRB_W-1:0]     databus_wstrb_o;
   logic [LEN_W-1:0]      databus_len_o;
   logic                  databus_last_o;

   // run table
   wu_cfg_t               row_cfg   [NUM_ROWS];
   string                 row_name  [NUM_ROWS];
   logic [7:0]            row_ready [NUM_ROWS];
   int                    row_cnt = 0;

   // mirror of the local buffer
   logic [DATA_W-1:0]     model_mem [BUF_DEPTH];
   logic                  pp_state = 1'b0;
   string                 cur_name = "reset";
   logic [DATA_W-1:0]     in_base = '0;
   int                    since_run = 0;
   // ready is high when a 7-bit draw is below this code so 128 means always
   logic [7:0]            ready_code = 8'd128;
   integer                seed = 32'hc3de;
   logic [31:0]           rnd;

   write_unit write_unit_i (
      .clk                    (clk),
      .rst                    (rst),
      .run_i                  (run_i),
      .done_o                 (done_o),
      .in_i                   (in_i),
      .cfg_store_start_i      (cfg.store_start),
      .cfg_store_incr_i       (cfg.store_incr),
      .cfg_store_stride_i     (cfg.store_stride),
      .cfg_store_period_i     (cfg.store_period),
      .cfg_store_iter_i       (cfg.store_iter),
      .cfg_store_delay_i      (cfg.store_delay),
      .cfg_xfer_enable_i      (cfg.xfer_enable),
      .cfg_xfer_amount_i      (cfg.xfer_amount),
      .cfg_xfer_ext_addr_i    (cfg.xfer_ext_addr),
      .cfg_xfer_len_i         (cfg.xfer_len),
      .cfg_xfer_addr_stride_i (cfg.xfer_addr_stride),
      .cfg_ping_pong_i        (cfg.ping_pong),
      .databus_valid_o        (databus_valid_o),
      .databus_ready_i        (databus_ready_i),
      .databus_addr_o         (databus_addr_o),
      .databus_wdata_o        (databus_wdata_o),
      .databus_wstrb_o        (databus_wstrb_o),
      .databus_len_o          (databus_len_o),
      .databus_last_o         (databus_last_o)
   );

   always #10 clk = ~clk;

   // datapath word is base plus cycles since the run
   always @(posedge clk) begin
      if (run_i) begin
         since_run <= 1;
         in_i      <= in_base + 32'd1;
      end else begin
         since_run <= since_run + 1;
         in_i      <= in_base + 32'(since_run + 1);
      end
   end

   // bus responder
   always @(posedge clk) begin
      rnd = $random(seed);
      databus_ready_i <= ({1'b0, rnd[6:0]} < ready_code);
   end

   task automatic stop_run(input string msg);
      $display("%s", msg);
      $display("*** FAILED ***");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_val(input string what, input logic [31:0] exp_val,
                            input logic [31:0] act_val);
      if (exp_val !== act_val) begin
         stop_run($sformatf("CHECK FAILED %s %s expected %08h actual %08h",
                            cur_name, what, exp_val, act_val));
      end
   endtask

   task automatic add_row(input string name, input int ready, input int st, input int inc,
                          input int strd, input int per, input int iter, input int dly,
                          input int xen, input int amt, input int ext, input int blen,
                          input int astr, input int pp);
      wu_cfg_t c;
      c.store_start      = BUF_ADDR_W'(st);
      c.store_incr       = BUF_ADDR_W'(inc);
      c.store_stride     = BUF_ADDR_W'(strd);
      c.store_period     = LOOP_W'(per);
      c.store_iter       = LOOP_W'(iter);
      c.store_delay      = DELAY_W'(dly);
      c.xfer_enable      = 1'(xen);
      c.xfer_amount      = BUF_ADDR_W'(amt);
      c.xfer_ext_addr    = AXI_ADDR_W'(ext);
      c.xfer_len         = LEN_W'(blen);
      c.xfer_addr_stride = AXI_ADDR_W'(astr);
      c.ping_pong        = 1'(pp);
      row_cfg[row_cnt]   = c;
      row_name[row_cnt]  = name;
      row_ready[row_cnt] = 8'(ready);
      row_cnt++;
   endtask

   // name, ready, start, incr, stride, period, iter, delay,
   // enable, amount, ext addr, len, addr stride, ping-pong
   task automatic load_table();
      add_row("fill_lower", 128, 0, 1, 16, 16, 8, 0,
              0, 0, 0, 1, 0, 0);
      add_row("strided_store", 128, 3, 2, 16, 5, 4, 3,
              0, 0, 0, 1, 0, 0);
      add_row("xfer_aligned", 128, 0, 0, 0, 4, 0, 2,
              1, 64, 32'h1000, 8, 32'h20, 0);
      add_row("xfer_short_tail", 128, 0, 0, 0, 0, 0, 0,
              1, 45, 32'h2000, 7, 32'h100, 0);
      add_row("xfer_ready_half", 64, 0, 0, 0, 0, 0, 0,
              1, 45, 32'h2000, 7, 32'h100, 0);
      add_row("xfer_ready_quarter", 32, 0, 0, 0, 0, 0, 0,
              1, 128, 32'h3000, 16, 32'h40, 0);
      add_row("pp_first", 96, 0, 1, 16, 16, 4, 1,
              1, 60, 32'h4000, 8, 32'h20, 1);
      add_row("pp_second", 64, 5, 3, 20, 6, 5, 4,
              1, 64, 32'h5000, 10, 32'h80, 1);
      add_row("pp_third", 128, 64, 1, 8, 8, 8, 0,
              1, 100, 32'h6000, 9, 32'h24, 1);
      add_row("pp_fourth", 32, 100, 5, 1, 3, 7, 6,
              1, 128, 32'h7000, 32, 32'h80, 1);
      add_row("pp_off_readback", 128, 0, 0, 0, 0, 0, 0,
              1, 50, 32'h8000, 6, 32'h18, 0);
   endtask

   // check beat n against read half rh of the model
   task automatic verify_beat(input wu_cfg_t c, input logic rh, input int n);
      int                    burst;
      int                    blen;
      logic [BUF_ADDR_W-1:0] ridx;
      logic                  exp_last;
      burst = n / int'(c.xfer_len);
      blen  = int'(c.xfer_amount) - burst * int'(c.xfer_len);
      if (blen > int'(c.xfer_len)) begin
         blen = int'(c.xfer_len);
      end
      ridx     = BUF_ADDR_W'(n);
      exp_last = ((n % int'(c.xfer_len)) == int'(c.xfer_len) - 1) ||
                 (n == int'(c.xfer_amount) - 1);
      check_val($sformatf("wdata beat %0d", n), model_mem[{rh, ridx[BUF_ADDR_W-2:0]}],
                databus_wdata_o);
      check_val($sformatf("addr beat %0d", n),
                c.xfer_ext_addr + 32'(burst) * c.xfer_addr_stride, databus_addr_o);
      check_val($sformatf("len beat %0d", n), 32'(blen), 32'(databus_len_o));
      check_val($sformatf("last beat %0d", n), 32'(exp_last), 32'(databus_last_o));
      check_val("wstrb", 32'h0000_000f, 32'(databus_wstrb_o));
   endtask

   task automatic apply_row(input int t);
      wu_cfg_t               c;
      logic                  sh;
      logic                  rh;
      logic                  stalled;
      logic                  done_seen;
      logic [31:0]           st_data;
      logic [31:0]           st_addr;
      logic [LEN_W-1:0]      st_len;
      logic                  st_last;
      logic [BUF_ADDR_W-1:0] waddr;
      int                    n_exp;
      int                    seen;
      int                    store_end;
      int                    cyc;
      c          = row_cfg[t];
      cur_name   = row_name[t];
      ready_code = row_ready[t];
      in_base    = {8'(t + 1), 24'h0};
      pp_state   = c.ping_pong ? !pp_state : 1'b0;
      sh         = c.ping_pong && pp_state;
      rh         = c.ping_pong && !pp_state;
      n_exp      = c.xfer_enable ? int'(c.xfer_amount) : 0;
      // cycle of the last store write after the run
      store_end  = (c.store_period == '0 || c.store_iter == '0) ? 0 :
                   int'(c.store_delay) + int'(c.store_period) * int'(c.store_iter);
      @(posedge clk);
      run_i <= 1'b1;
      cfg   <= c;
      @(posedge clk);
      run_i <= 1'b0;
      seen      = 0;
      stalled   = 1'b0;
      done_seen = 1'b0;
      st_data   = '0;
      st_addr   = '0;
      st_len    = '0;
      st_last   = 1'b0;
      for (cyc = 1; cyc <= RUN_TIMEOUT && !done_seen; cyc++) begin
         @(negedge clk);
         if (cyc == 1) begin
            check_val("done_o low after run", 32'd0, 32'(done_o));
         end
         if (databus_valid_o && seen >= n_exp) begin
            stop_run($sformatf("%s: bus beat beyond the %0d expected", cur_name, n_exp));
         end
         if (databus_valid_o && stalled) begin
            check_val("wdata held in stall", st_data, databus_wdata_o);
            check_val("addr held in stall", st_addr, databus_addr_o);
            check_val("len held in stall", 32'(st_len), 32'(databus_len_o));
            check_val("last held in stall", 32'(st_last), 32'(databus_last_o));
         end
         if (databus_valid_o && databus_ready_i) begin
            verify_beat(c, rh, seen);
            seen++;
         end
         stalled = databus_valid_o && !databus_ready_i;
         st_data = databus_wdata_o;
         st_addr = databus_addr_o;
         st_len  = databus_len_o;
         st_last = databus_last_o;
         if (done_o) begin
            if (cyc <= store_end) begin
               stop_run($sformatf("%s: done_o rose before the store pattern ended",
                                  cur_name));
            end
            check_val("beat count", 32'(n_exp), 32'(seen));
            done_seen = 1'b1;
         end
      end
      if (!done_seen) begin
         stop_run($sformatf("%s: timeout waiting for done_o", cur_name));
      end
      // apply the store rule once the transfer has read the old contents
      for (int i = 0; i < int'(c.store_iter); i++) begin
         for (int j = 0; j < int'(c.store_period); j++) begin
            waddr = c.store_start + BUF_ADDR_W'(i) * c.store_stride +
                    BUF_ADDR_W'(j) * c.store_incr;
            model_mem[{sh, waddr[BUF_ADDR_W-2:0]}] =
               in_base + 32'(int'(c.store_delay) + 1 + i * int'(c.store_period) + j);
         end
      end
   endtask

   initial begin
      rst   <= 1'b1;
      run_i <= 1'b0;
      cfg   <= '0;
      load_table();
      repeat (8) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      check_val("done_o after reset", 32'd1, 32'(done_o));
      check_val("valid after reset", 32'd0, 32'(databus_valid_o));
      for (int t = 0; t < NUM_ROWS; t++) begin
         apply_row(t);
      end
      $display("*** PASSED ***");
      $finish;
   end

endmodule

`default_nettype wire

// ==== word_stream_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface word_stream_if
   import wu_cfg_pkg::*;
();

   logic              valid;
   logic              ready;
   logic [DATA_W-1:0] data;
   // final word of the whole transfer
   logic              last;

   modport src (output valid, output data, output last, input ready);
   modport dst (input valid, input data, input last, output ready);

endinterface

`default_nettype wire

// ==== write_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module write_unit
   import wu_bus_pkg::*;
   import wu_cfg_pkg::*;
(
   input  wire                   clk,
   input  wire                   rst,
   input  wire                   run_i,
   output logic                  done_o,
   input  wire  [DATA_W-1:0]     in_i,
   input  wire  [BUF_ADDR_W-1:0] cfg_store_start_i,
   input  wire  [BUF_ADDR_W-1:0] cfg_store_incr_i,
   input  wire  [BUF_ADDR_W-1:0] cfg_store_stride_i,
   input  wire  [LOOP_W-1:0]     cfg_store_period_i,
   input  wire  [LOOP_W-1:0]     cfg_store_iter_i,
   input  wire  [DELAY_W-1:0]    cfg_store_delay_i,
   input  wire                   cfg_xfer_enable_i,
   input  wire  [BUF_ADDR_W-1:0] cfg_xfer_amount_i,
   input  wire  [AXI_ADDR_W-1:0] cfg_xfer_ext_addr_i,
   input  wire  [LEN_W-1:0]      cfg_xfer_len_i,
   input  wire  [AXI_ADDR_W-1:0] cfg_xfer_addr_stride_i,
   input  wire                   cfg_ping_pong_i,
   output logic                  databus_valid_o,
   input  wire                   databus_ready_i,
   output logic [AXI_ADDR_W-1:0] databus_addr_o,
   output logic [AXI_DATA_W-1:0] databus_wdata_o,
   output logic [STRB_W-1:0]     databus_wstrb_o,
   output logic [LEN_W-1:0]      databus_len_o,
   output logic                  databus_last_o
);

   wu_cfg_t               cfg_in;
   wu_cfg_t               cfg_q;
   wu_cfg_t               cfg;
   logic                  pp_state_q;
   logic                  store_half;
   logic                  read_half;
   logic                  store_we;
   logic [BUF_ADDR_W-1:0] store_addr;
   logic                  store_done;
   logic                  rd_en;
   logic [BUF_ADDR_W-1:0] rd_addr;
   logic [DATA_W-1:0]     rd_data;
   logic                  xfer_done;

   word_stream_if stream_if ();

   always_comb begin
      cfg_in.store_start      = cfg_store_start_i;
      cfg_in.store_incr       = cfg_store_incr_i;
      cfg_in.store_stride     = cfg_store_stride_i;
      cfg_in.store_period     = cfg_store_period_i;
      cfg_in.store_iter       = cfg_store_iter_i;
      cfg_in.store_delay      = cfg_store_delay_i;
      cfg_in.xfer_enable      = cfg_xfer_enable_i;
      cfg_in.xfer_amount      = cfg_xfer_amount_i;
      cfg_in.xfer_ext_addr    = cfg_xfer_ext_addr_i;
      cfg_in.xfer_len         = cfg_xfer_len_i;
      cfg_in.xfer_addr_stride = cfg_xfer_addr_stride_i;
      cfg_in.ping_pong        = cfg_ping_pong_i;
   end

   always_ff @(posedge clk) begin
      if (run_i) begin
         cfg_q <= cfg_in;
      end
   end

   // blocks see the new settings already in the run cycle
   assign cfg = run_i ? cfg_in : cfg_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         pp_state_q <= 1'b0;
      end else if (run_i) begin
         pp_state_q <= cfg_in.ping_pong ? !pp_state_q : 1'b0;
      end
   end

   // both sides share the lower half without ping-pong
   assign store_half = cfg_q.ping_pong && pp_state_q;
   assign read_half  = cfg_q.ping_pong && !pp_state_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         done_o <= 1'b1;
      end else if (run_i) begin
         done_o <= 1'b0;
      end else if (store_done && xfer_done) begin
         done_o <= 1'b1;
      end
   end

   store_addr_gen store_addr_gen_i (
      .clk    (clk),
      .rst    (rst),
      .run_i  (run_i),
      .cfg_i  (cfg),
      .half_i (store_half),
      .we_o   (store_we),
      .addr_o (store_addr),
      .done_o (store_done)
   );

   dual_port_buffer dual_port_buffer_i (
      .clk     (clk),
      .we_i    (store_we),
      .waddr_i (store_addr),
      .wdata_i (in_i),
      .re_i    (rd_en),
      .raddr_i (rd_addr),
      .rdata_o (rd_data)
   );

   buffer_reader buffer_reader_i (
      .clk     (clk),
      .rst     (rst),
      .run_i   (run_i),
      .cfg_i   (cfg),
      .half_i  (read_half),
      .re_o    (rd_en),
      .raddr_o (rd_addr),
      .rdata_i (rd_data),
      .out     (stream_if.src)
   );

   burst_writer burst_writer_i (
      .clk             (clk),
      .rst             (rst),
      .run_i           (run_i),
      .cfg_i           (cfg),
      .in              (stream_if.dst),
      .databus_valid_o (databus_valid_o),
      .databus_ready_i (databus_ready_i),
      .databus_addr_o  (databus_addr_o),
      .databus_wdata_o (databus_wdata_o),
      .databus_wstrb_o (databus_wstrb_o),
      .databus_len_o   (databus_len_o),
      .databus_last_o  (databus_last_o),
      .done_o          (xfer_done)
   );

endmodule

`default_nettype wire

// ==== wu_bus_pkg.sv ====
`default_nettype none

package wu_bus_pkg;

   // master databus address and data widths
   localparam int AXI_ADDR_W = 32;
   localparam int AXI_DATA_W = 32;

   // one strobe bit per byte lane
   localparam int STRB_W = AXI_DATA_W / 8;

   // beat count of one burst
   // a burst carries at most 2**LEN_W-1 beats
   localparam int LEN_W = 8;

   // only full-word writes are issued
   localparam logic [STRB_W-1:0] WSTRB_ALL = '1;

endpackage

`default_nettype wire

// ==== wu_cfg_pkg.sv ====
`default_nettype none

package wu_cfg_pkg;

   import wu_bus_pkg::*;

   // top address bit of the local buffer picks the ping-pong half
   localparam int BUF_ADDR_W = 8;
   localparam int BUF_DEPTH  = 2 ** BUF_ADDR_W;

   // datapath word
   localparam int DATA_W = 32;

   // store pattern counters
   localparam int LOOP_W  = 7;
   localparam int DELAY_W = 8;

   typedef struct packed {
      logic [BUF_ADDR_W-1:0] store_start;
      logic [BUF_ADDR_W-1:0] store_incr;
      logic [BUF_ADDR_W-1:0] store_stride;
      logic [LOOP_W-1:0]     store_period;
      logic [LOOP_W-1:0]     store_iter;
      logic [DELAY_W-1:0]    store_delay;
      logic                  xfer_enable;
      logic [BUF_ADDR_W-1:0] xfer_amount;
      logic [AXI_ADDR_W-1:0] xfer_ext_addr;
      logic [LEN_W-1:0]      xfer_len;
      logic [AXI_ADDR_W-1:0] xfer_addr_stride;
      logic                  ping_pong;
   } wu_cfg_t;

endpackage

`default_nettype wire
